/* sim/bcd_stimulus.txt */
# columns, all hex: value, expected bcd word, seg of position 0, 1, 2 (g..a, blanked = 00)
# position 0 is the ones digit
00 000 3f 00 00
01 001 06 00 00
05 005 6d 00 00
09 009 6f 00 00
0a 010 3f 06 00
0b 011 06 06 00
13 019 6f 06 00
14 020 3f 5b 00
20 032 5b 4f 00
2a 042 5b 66 00
39 057 07 6d 00
3f 063 4f 7d 00
40 064 66 7d 00
4d 077 07 07 00
4e 078 7f 07 00
56 086 7d 7f 00
63 099 6f 6f 00
64 100 3f 3f 06
65 101 06 3f 06
6d 109 6f 3f 06
6e 110 3f 06 06
7f 127 07 5b 06
80 128 7f 5b 06
96 150 3f 6d 06
a8 168 7f 7d 06
b4 180 3f 7f 06
c7 199 6f 6f 06
c8 200 3f 3f 5b
cd 205 6d 3f 5b
d5 213 4f 06 5b
de 222 5b 5b 5b
ea 234 66 4f 5b
f0 240 3f 66 5b
f9 249 6f 66 5b
fa 250 3f 6d 5b
fe 254 66 6d 5b
ff 255 6d 6d 5b

/* files.f */
+incdir+logic
logic/bcd_pkg.sv
logic/bcd.sv
logic/sevenseg_scan.sv
logic/bcd_display.sv
sim/bcd_display_props.sv
sim/bcd_display_tb.sv

/* Bender.yml */
package:
  name: bcd_display

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/bcd_pkg.sv
      - logic/bcd.sv
      - logic/sevenseg_scan.sv
      - logic/bcd_display.sv

  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/bcd_display_props.sv
      - sim/bcd_display_tb.sv

/* sim/bcd_display_tb.sv */
/*
 * testbench for the decimal readout with file and random values, conversion timing,
 * held result, scan patterns with blanking and a start ignored while busy
 */

`timescale 1ns/1ps
`default_nettype none

`include "bcd_cfg.svh"

module bcd_display_tb;

	localparam int CLK_PERIOD  = 4;
	localparam int CONV_CYCLES = 2 + (`BCD_IN_BITS - 1) * (`BCD_NUM_DIGITS + 2);
	localparam int SCAN_CYCLES = `BCD_NUM_DIGITS * `BCD_SCAN_DIV;
	localparam int NUM_RANDOM  = 12;
	localparam int STRAY_CYCLE = 10;
	localparam STIM_FILE = "sim/bcd_stimulus.txt";

	// input value of one test and the readout it should give
	typedef struct packed {
		bcd_pkg::num_t                       value;
		bcd_pkg::bcd_word_t                  bcd;
		bcd_pkg::seg_t [`BCD_NUM_DIGITS-1:0] segs;
	} vector_t;

	logic               in_clk;
	logic               in_rst;
	logic               start;
	bcd_pkg::num_t      num;
	bcd_pkg::bcd_word_t bcd;
	logic               finished;
	bcd_pkg::disp_t     disp;

	vector_t            vectors[$];
	bcd_pkg::bcd_word_t last_bcd;
	int                 edge_cnt;
	int                 checks;
	int                 errors;
	int                 tests;
	int                 watchdog_ns;
	bit                 limit_ready;

	bcd_display bcd_display_inst (
		.in_clk   (in_clk),
		.in_rst   (in_rst),
		.start    (start),
		.num      (num),
		.bcd      (bcd),
		.finished (finished),
		.disp     (disp)
	);

	always #(CLK_PERIOD / 2) in_clk = ~in_clk;

	// clock edges since reset release give the expected scan position
	always @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			edge_cnt <= 0;
		end else begin
			edge_cnt <= edge_cnt + 1;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// seven-segment table in g..a order
	function automatic bcd_pkg::seg_t segment_pattern(input bcd_pkg::digit_t d);
		case (d)
			4'd0:    return 7'h3f;
			4'd1:    return 7'h06;
			4'd2:    return 7'h5b;
			4'd3:    return 7'h4f;
			4'd4:    return 7'h66;
			4'd5:    return 7'h6d;
			4'd6:    return 7'h7d;
			4'd7:    return 7'h07;
			4'd8:    return 7'h7f;
			4'd9:    return 7'h6f;
			default: return 7'h00;
		endcase
	endfunction

	// decimal digits by division and blanking from the top down
	function automatic vector_t make_vector(input bcd_pkg::num_t value);
		vector_t v;
		int rest;
		int i;
		bit lead;
		v.value = value;
		rest = value;
		for (i = 0; i < `BCD_NUM_DIGITS; i++) begin
			v.bcd[i] = bcd_pkg::digit_t'(rest % 10);
			rest = rest / 10;
		end
		lead = 1'b1;
		for (i = `BCD_NUM_DIGITS - 1; i >= 0; i--) begin
			if (v.bcd[i] != 4'd0) begin
				lead = 1'b0;
			end
			v.segs[i] = (lead && i != 0) ? 7'h00 : segment_pattern(v.bcd[i]);
		end
		return v;
	endfunction

	// disp is registered and lags the position counter by one edge
	function automatic bcd_pkg::disp_t expected_disp(input vector_t v);
		bcd_pkg::disp_t d;
		int pos;
		pos = (edge_cnt == 0) ? 0 : ((edge_cnt - 1) / `BCD_SCAN_DIV) % `BCD_NUM_DIGITS;
		d.anode = '0;
		d.anode[pos] = 1'b1;
		d.seg = v.segs[pos];
		return d;
	endfunction

	task automatic check_bcd(input bcd_pkg::bcd_word_t actual,
			input bcd_pkg::bcd_word_t expected, input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED %0t: %s, bcd %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic check_disp(input bcd_pkg::disp_t actual,
			input bcd_pkg::disp_t expected, input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED %0t: %s, seg %h anode %b, expected seg %h anode %b", $time, what,
				actual.seg, actual.anode, expected.seg, expected.anode);
		end
	endtask

	task automatic check_finished(input logic actual, input logic expected, input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED %0t: %s, finished %b, expected %b", $time, what, actual, expected);
		end
	endtask

	task automatic load_stimulus();
		int fd;
		int rc;
		int value;
		int word;
		int s0;
		int s1;
		int s2;
		string line;
		vector_t v;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the stimulus file %s", STIM_FILE);
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			rc = $fgets(line, fd);
			if (rc > 0 && line[0] != "#") begin
				if ($sscanf(line, "%h %h %h %h %h", value, word, s0, s1, s2) == 5) begin
					v.value   = bcd_pkg::num_t'(value);
					v.bcd     = bcd_pkg::bcd_word_t'(word);
					v.segs[0] = bcd_pkg::seg_t'(s0);
					v.segs[1] = bcd_pkg::seg_t'(s1);
					v.segs[2] = bcd_pkg::seg_t'(s2);
					vectors.push_back(v);
				end
			end
		end
		$fclose(fd);
	endtask

	// one conversion with an optional second start while busy
	task automatic run_conversion(input vector_t vec, input bit stray);
		int cycles;
		int i;
		bit rose;
		tests++;
		@(posedge in_clk);
		start <= 1'b1;
		num   <= vec.value;
		@(posedge in_clk);
		start <= 1'b0;
		num   <= ~vec.value;
		@(negedge in_clk);
		check_finished(finished, 1'b0, "finished after start");
		check_bcd(bcd, last_bcd, "bcd held during conversion");
		cycles = 0;
		rose = 1'b0;
		while (!rose && cycles < 2 * CONV_CYCLES) begin
			@(posedge in_clk);
			cycles++;
			if (stray && cycles == STRAY_CYCLE) begin
				start <= 1'b1;
				num   <= ~vec.value;
			end else begin
				start <= 1'b0;
			end
			@(negedge in_clk);
			check_bcd(bcd, last_bcd, "bcd held during conversion");
			rose = (finished === 1'b1);
		end
		if (!rose) begin
			errors++;
			$display("finished never rose after the start for value %0d", vec.value);
		end else if (cycles != CONV_CYCLES) begin
			errors++;
			$display("FAILED %0t: conversion of %0d took %0d cycles, expected %0d", $time,
				vec.value, cycles, CONV_CYCLES);
		end
		@(negedge in_clk);
		check_bcd(bcd, vec.bcd, "bcd after conversion");
		last_bcd = vec.bcd;
		// one extra cycle for the registered bus and then a full scan round
		@(negedge in_clk);
		for (i = 0; i < SCAN_CYCLES; i++) begin
			@(negedge in_clk);
			check_disp(disp, expected_disp(vec), "scan pattern");
		end
	endtask

	initial begin : main
		logic [31:0] seed;
		int i;
		in_clk      = 1'b0;
		in_rst      = 1'b1;
		start       = 1'b0;
		num         = '0;
		checks      = 0;
		errors      = 0;
		tests       = 0;
		last_bcd    = '0;
		limit_ready = 1'b0;
		load_stimulus();
		watchdog_ns = (vectors.size() + NUM_RANDOM + 4)
			* (CONV_CYCLES + 3 * SCAN_CYCLES + 10) * CLK_PERIOD;
		limit_ready = 1'b1;
		repeat (5) @(posedge in_clk);
		in_rst <= 1'b0;
		@(negedge in_clk);
		check_finished(finished, 1'b1, "finished after reset");
		check_bcd(bcd, '0, "bcd after reset");
		check_disp(disp, expected_disp(make_vector('0)), "disp after reset");
		for (i = 0; i < vectors.size(); i++) begin
			run_conversion(vectors[i], (i % 5) == 2);
		end
		seed = 32'hd807_85be;
		for (i = 0; i < NUM_RANDOM; i++) begin
			seed = xorshift32(seed);
			run_conversion(make_vector(seed[`BCD_IN_BITS-1:0]), (i % 4) == 1);
		end
		// bound assertion failures count as errors
		errors += bcd_display_inst.bcd_display_props_inst.fail_cnt;
		$display("bcd_display_tb: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	initial begin : watchdog
		wait (limit_ready);
		#(watchdog_ns);
		$display("timeout: the run did not finish within %0d ns", watchdog_ns);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/bcd_display_props.sv */
/*
 * bound checks on the readout for one-hot anode, start handling and the held result
 */

`timescale 1ns/1ps
`default_nettype none

module bcd_display_props (
	input wire logic               in_clk,
	input wire logic               in_rst,
	input wire logic               start,
	input wire logic               finished,
	input wire bcd_pkg::bcd_word_t bcd,
	input wire bcd_pkg::disp_t     disp
);

	// assertion failures so far
	int unsigned fail_cnt = 0;

	// exactly one digit driven at a time
	anode_onehot: assert property (
		@(posedge in_clk) disable iff (in_rst)
		$onehot(disp.anode)
	) else begin
		fail_cnt++;
		$error("anode select is not one-hot");
	end

	// a start taken while idle begins a conversion
	start_taken: assert property (
		@(posedge in_clk) disable iff (in_rst)
		(start && finished) |=> !finished
	) else begin
		fail_cnt++;
		$error("finished stayed high after a start");
	end

	// latch only follows the converter while idle
	bcd_held: assert property (
		@(posedge in_clk) disable iff (in_rst)
		!finished |=> $stable(bcd)
	) else begin
		fail_cnt++;
		$error("bcd changed during a conversion");
	end

endmodule

bind bcd_display bcd_display_props bcd_display_props_inst (
	.in_clk   (in_clk),
	.in_rst   (in_rst),
	.start    (start),
	.finished (finished),
	.bcd      (bcd),
	.disp     (disp)
);

`default_nettype wire

/* logic/bcd_display.sv */
/*
 * decimal readout top: converter feeding the multiplexed segment driver
 */

`timescale 1ns/1ps
`default_nettype none

module bcd_display (
	input  wire logic              in_clk,
	input  wire logic              in_rst,
	// one-cycle strobe, taken only while finished
	input  wire logic              start,
	input  wire bcd_pkg::num_t     num,
	// last finished result, held during a conversion
	output bcd_pkg::bcd_word_t     bcd,
	output logic                   finished,
	output bcd_pkg::disp_t         disp
);

	// converter working register, valid while finished
	bcd_pkg::bcd_word_t conv_result;
	logic conv_finished;

	bcd bcd_inst (
		.in_clk   (in_clk),
		.in_rst   (in_rst),
		.start    (start),
		.num      (num),
		.result   (conv_result),
		.finished (conv_finished)
	);

	sevenseg_scan sevenseg_scan_inst (
		.in_clk   (in_clk),
		.in_rst   (in_rst),
		.result   (conv_result),
		.finished (conv_finished),
		.shown    (bcd),
		.disp     (disp)
	);

	assign finished = conv_finished;

endmodule

`default_nettype wire

/* logic/sevenseg_scan.sv */
/*
 * result latch, digit scan, leading-zero blanking and seven-segment decoder
 */

`timescale 1ns/1ps
`default_nettype none

`include "bcd_cfg.svh"

module sevenseg_scan (
	input  wire logic               in_clk,
	input  wire logic               in_rst,
	input  wire bcd_pkg::bcd_word_t result,
	input  wire logic               finished,
	output bcd_pkg::bcd_word_t      shown,
	output bcd_pkg::disp_t          disp
);

	localparam int DIV_W = (`BCD_SCAN_DIV > 1) ? $clog2(`BCD_SCAN_DIV) : 1;
	localparam int POS_W = (`BCD_NUM_DIGITS > 1) ? $clog2(`BCD_NUM_DIGITS) : 1;

	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`BCD_SCAN_DIV - 1);
	localparam logic [POS_W-1:0] POS_LAST = POS_W'(`BCD_NUM_DIGITS - 1);

	logic [DIV_W-1:0] div_cnt;
	logic [POS_W-1:0] pos;

	// digit i and all above it are zero
	logic [`BCD_NUM_DIGITS-1:0] lead_zero;
	logic [`BCD_NUM_DIGITS-1:0] blank;

	bcd_pkg::disp_t disp_next;

	// standard table, g..a, codes above 9 dark
	function automatic bcd_pkg::seg_t seg_decode(input bcd_pkg::digit_t d);
		case (d)
			4'd0:    seg_decode = 7'h3f;
			4'd1:    seg_decode = 7'h06;
			4'd2:    seg_decode = 7'h5b;
			4'd3:    seg_decode = 7'h4f;
			4'd4:    seg_decode = 7'h66;
			4'd5:    seg_decode = 7'h6d;
			4'd6:    seg_decode = 7'h7d;
			4'd7:    seg_decode = 7'h07;
			4'd8:    seg_decode = 7'h7f;
			4'd9:    seg_decode = 7'h6f;
			default: seg_decode = 7'h00;
		endcase
	endfunction

	// hold the last finished value through a conversion
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			shown <= '0;
		end else if (finished) begin
			shown <= result;
		end
	end

	// free-running divider and position counter
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			div_cnt <= '0;
			pos     <= '0;
		end else if (div_cnt == DIV_LAST) begin
			div_cnt <= '0;
			if (pos == POS_LAST) begin
				pos <= '0;
			end else begin
				pos <= pos + 1'b1;
			end
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// leading zeros from the top, ones place always shown
	always_comb begin
		for (int i = `BCD_NUM_DIGITS - 1; i >= 0; i--) begin
			if (i == `BCD_NUM_DIGITS - 1) begin
				lead_zero[i] = (shown[i] == 4'd0);
			end else begin
				lead_zero[i] = (shown[i] == 4'd0) && lead_zero[i+1];
			end
			blank[i] = lead_zero[i] && (i != 0);
		end
	end

	always_comb begin
		disp_next.anode = '0;
		disp_next.anode[pos] = 1'b1;
		if (blank[pos]) begin
			disp_next.seg = '0;
		end else begin
			disp_next.seg = seg_decode(shown[pos]);
		end
	end

	// registered bus, comes up as a lit 0 on position 0
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			disp.seg   <= 7'h3f;
			disp.anode <= `BCD_NUM_DIGITS'(1);
		end else begin
			disp <= disp_next;
		end
	end

endmodule

`default_nettype wire

/* logic/bcd.sv */
/*
 * sequential double-dabble binary to bcd converter
 * one shift or one digit correction per clock, start strobe and finished level
 */

`timescale 1ns/1ps
`default_nettype none

`include "bcd_cfg.svh"

module bcd (
	input  wire logic              in_clk,
	input  wire logic              in_rst,
	input  wire logic              start,
	input  wire bcd_pkg::num_t     num,
	output bcd_pkg::bcd_word_t     result,
	output logic                   finished
);

	localparam int BIT_IDX_W = (`BCD_IN_BITS > 1) ? $clog2(`BCD_IN_BITS) : 1;
	localparam int DIG_IDX_W = (`BCD_NUM_DIGITS > 1) ? $clog2(`BCD_NUM_DIGITS) : 1;

	localparam logic [BIT_IDX_W-1:0] BIT_TOP = BIT_IDX_W'(`BCD_IN_BITS - 1);
	localparam logic [DIG_IDX_W-1:0] DIG_TOP = DIG_IDX_W'(`BCD_NUM_DIGITS - 1);

	typedef enum logic [2:0] {
		Idle,
		Load,
		Shift,
		Add,
		NextIndex
	} state_t;

	state_t state, state_next;

	bcd_pkg::bcd_word_t bcdnum, bcdnum_next;
	logic [BIT_IDX_W-1:0] bitidx, bitidx_next;
	logic [DIG_IDX_W-1:0] digidx, digidx_next;

	// copy of the number taken with start
	bcd_pkg::num_t num_q;

	// flat view for the one-bit shift
	logic [`BCD_WORD_BITS-1:0] bcd_flat;

	logic take_start;

	// start only counts while idle
	assign take_start = (state == Idle) && start;

	assign bcd_flat = bcdnum;

	assign result   = bcdnum;
	assign finished = (state == Idle);

	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			state  <= Idle;
			bcdnum <= '0;
			bitidx <= BIT_TOP;
			digidx <= DIG_TOP;
		end else begin
			state  <= state_next;
			bcdnum <= bcdnum_next;
			bitidx <= bitidx_next;
			digidx <= digidx_next;
		end
	end

	// caller need not hold num past the start cycle
	always_ff @(posedge in_clk) begin
		if (take_start) begin
			num_q <= num;
		end
	end

	always_comb begin
		state_next  = state;
		bcdnum_next = bcdnum;
		bitidx_next = bitidx;
		digidx_next = digidx;

		case (state)
			Idle: begin
				if (take_start) begin
					state_next = Load;
				end
			end

			Load: begin
				bcdnum_next = '0;
				bitidx_next = BIT_TOP;
				digidx_next = DIG_TOP;
				state_next  = Shift;
			end

			Shift: begin
				// msb first into the ones digit
				bcdnum_next = {bcd_flat[`BCD_WORD_BITS-2:0], num_q[bitidx]};
				// last bit needs no correction pass
				if (bitidx != '0) begin
					state_next = Add;
				end else begin
					state_next = Idle;
				end
			end

			Add: begin
				if (bcdnum[digidx] >= 4'd5) begin
					bcdnum_next[digidx] = bcdnum[digidx] + 4'd3;
				end
				if (digidx != '0) begin
					digidx_next = digidx - 1'b1;
				end else begin
					digidx_next = DIG_TOP;
					state_next  = NextIndex;
				end
			end

			NextIndex: begin
				bitidx_next = bitidx - 1'b1;
				state_next  = Shift;
			end

			default: begin
				state_next = Idle;
			end
		endcase
	end

endmodule

`default_nettype wire

/* logic/bcd_pkg.sv */
/*
 * shared types: bcd digit and word, segment lines, display bus, input number
 */

`default_nettype none

`include "bcd_cfg.svh"

package bcd_pkg;

	// one decimal digit, 0..9
	typedef logic [3:0] digit_t;

	// digit 0 is the ones place, low bits
	typedef digit_t [`BCD_NUM_DIGITS-1:0] bcd_word_t;

	// segments g down to a, 1 = lit
	typedef logic [6:0] seg_t;

	// unsigned binary input
	typedef logic [`BCD_IN_BITS-1:0] num_t;

	// multiplexed display bus
	typedef struct packed {
		// pattern of the selected digit
		seg_t seg;
		// one-hot digit select, active high
		logic [`BCD_NUM_DIGITS-1:0] anode;
	} disp_t;

endpackage

`default_nettype wire

/* logic/bcd_cfg.svh */
/*
 * build-time sizes for the decimal readout: input width, digit count, scan period
 */

`ifndef BCD_CFG_SVH
`define BCD_CFG_SVH

// width of the unsigned binary input
`define BCD_IN_BITS 8

// decimal digits, enough for the largest input (255 needs 3)
`define BCD_NUM_DIGITS 3

// bits of a packed bcd word
`define BCD_WORD_BITS (`BCD_NUM_DIGITS * 4)

// clock cycles each digit stays lit
// short for simulation, raise for a real display
`define BCD_SCAN_DIV 4

`endif
